/* dv/lsu_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_checker (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     ack,
    input  wire lsu_pkg::lsu_resp_t resp,
    input  wire lsu_pkg::lsu_resp_t expected,
    output int                      checks,
    output int                      errors
);

    import lsu_pkg::*;

    logic ack_q;

    // resp is valid while ack is high, so compare once at its rise
    always @(posedge clk) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            checks <= 0;
            errors <= 0;
        end else begin
            ack_q <= ack;
            if (ack && !ack_q) begin
                checks <= checks + 1;
                if (resp !== expected) begin
                    errors <= errors + 1;
                    $display("Fail %0t: inst %0h got data %h phy %0d hit %b",
                             $time, resp.inst_num, resp.data, resp.phy, resp.hit);
                    $display("Fail %0t: inst %0h expected data %h phy %0d hit %b",
                             $time, expected.inst_num, expected.data, expected.phy,
                             expected.hit);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/lsu_stim.txt */
# op f3 addr data inst phy exp_data exp_hit rep   (hex except rep, which is decimal)
# rep>1 steps addr by 4 and data, inst by 1; B parks a store until the next C row
S 2 00000100 1234c5a7 00000010 11 00000000 0 1
L 2 00000100 00000000 00000011 21 1234c5a7 1 1
L 1 00000100 00000000 00000012 22 ffffc5a7 1 1
L 0 00000100 00000000 00000013 23 ffffffa7 1 1
L 5 00000100 00000000 00000014 24 0000c5a7 1 1
L 4 00000100 00000000 00000015 25 000000a7 1 1
S 0 00000200 deadbe9f 00000016 12 00000000 0 1
L 2 00000200 00000000 00000017 26 0000009f 1 1
S 1 00000300 cafe8001 00000018 13 00000000 0 1
L 1 00000300 00000000 00000019 27 ffff8001 1 1
L 2 00000400 00000000 0000001a 28 00000000 0 1
S 2 00000100 aaaa5555 00000020 14 00000000 0 1
L 2 00000100 00000000 00000021 29 aaaa5555 1 1
S 2 00000100 bbbbbbbb 0000001f 15 00000000 0 1
L 2 00000100 00000000 00000022 2a aaaa5555 1 1
C 0 00000100 00000000 00000020 00 00000000 0 1
L 2 00000100 00000000 00000023 2b 00000000 0 1
C 0 00000200 00000000 00000099 00 00000000 0 1
L 0 00000200 00000000 00000024 2c ffffff9f 1 1
F 0 00000000 00000000 00000000 00 00000000 0 1
L 0 00000200 00000000 00000025 2d 00000000 0 1
L 1 00000300 00000000 00000026 2e 00000000 0 1
S 2 00001000 11110000 00000100 16 00000000 0 32
B 2 00001080 22222222 00000120 17 00000000 0 1
C 0 00001000 00000000 00000100 00 00000000 0 1
L 2 00001080 00000000 00000121 2f 22222222 1 1
L 2 00001000 00000000 00000122 30 00000000 0 1

/* dv/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

    import lsu_pkg::*;

    localparam int WAIT_MAX   = 50;
    localparam int STALL_SPAN = 10;  // Cycles a store on a full buffer stays unacked
    localparam logic [PHY_W-1:0] STORE_PHY = 8'd160;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic        flush;
    logic        ack;
    lsu_req_t    mem_req;
    rob_commit_t commit;
    lsu_resp_t   resp;
    lsu_resp_t   expected;
    int          checks;
    int          errors;
    int          drive_errors;  // Timeouts and handshake faults
    logic        held;          // Store parked on a full buffer

    lsu_top UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .mem_req (mem_req),
        .commit  (commit),
        .flush   (flush),
        .ack     (ack),
        .resp    (resp)
    );

    lsu_checker checker_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ack      (ack),
        .resp     (resp),
        .expected (expected),
        .checks   (checks),
        .errors   (errors)
    );

    always #10 clk = ~clk;

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ack !== level && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (ack !== level) begin
            $display("%0t: timeout waiting for ack %s", $time, level ? "high" : "low");
            drive_errors++;
        end
    endtask

    task automatic start_request(input lsu_req_t r, input lsu_resp_t e, input logic stall);
        @(posedge clk);
        mem_req  <= r;
        expected <= e;
        req      <= 1'b1;
        if (stall) begin
            repeat (STALL_SPAN) begin
                @(posedge clk);
                if (ack) begin
                    $display("%0t: store acknowledged while the buffer was full", $time);
                    drive_errors++;
                end
            end
            held = 1'b1;
        end
    endtask

    task automatic finish_request();
        wait_ack(1'b1);
        req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic pulse_commit(input logic [XLEN-1:0] a, input logic [INST_W-1:0] i);
        @(posedge clk);
        commit.valid    <= 1'b1;
        commit.addr     <= a;
        commit.inst_num <= i;
        @(posedge clk);
        commit.valid <= 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic run_row(input logic [7:0] op, input logic [2:0] f3,
                           input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                           input logic [INST_W-1:0] inst, input logic [PHY_W-1:0] phy,
                           input logic [XLEN-1:0] exp_data, input logic exp_hit);
        lsu_req_t  r;
        lsu_resp_t e;
        r.kind     = (op == "L") ? OP_LOAD : OP_STORE;
        r.funct3   = f3;
        r.phy      = phy;
        r.inst_num = inst;
        r.addr     = addr;
        r.data     = data;
        e.data     = exp_data;
        e.hit      = exp_hit;
        e.inst_num = inst;
        e.phy      = (op == "L") ? phy : STORE_PHY;  // Stores write no register
        if (op == "S" || op == "L") begin
            start_request(r, e, 1'b0);
            finish_request();
        end else if (op == "B") begin
            start_request(r, e, 1'b1);
        end else if (op == "C") begin
            pulse_commit(addr, inst);
            if (held) begin
                held = 1'b0;
                finish_request();  // Freed entry lets the parked store through
            end
        end else if (op == "F") begin
            pulse_flush();
        end else begin
            $display("unknown op %s in stimulus file", op);
            drive_errors++;
        end
    endtask

    initial begin
        logic [7:0]         op;
        logic [2:0]         f3;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    data;
        logic [INST_W-1:0]  inst;
        logic [PHY_W-1:0]   phy;
        logic [XLEN-1:0]    exp_data;
        logic               exp_hit;
        logic [8*128-1:0]   line;
        int                 fd;
        int                 code;
        int                 rep;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = 1'b0;
        flush        = 1'b0;
        mem_req      = '0;
        commit       = '0;
        expected     = '0;
        drive_errors = 0;
        held         = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("dv/lsu_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file dv/lsu_stim.txt");
            drive_errors++;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %d",
                                   f3, addr, data, inst, phy, exp_data, exp_hit, rep);
                    if (code != 8) begin
                        $display("malformed row in stimulus file");
                        drive_errors++;
                        break;
                    end
                    for (int k = 0; k < rep; k++) begin
                        run_row(op, f3, addr + 4 * k, data + k, inst + k, phy,
                                exp_data, exp_hit);
                    end
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, compare errors %0d, driver errors %0d",
                 checks, errors, drive_errors);
        if (errors == 0 && drive_errors == 0 && checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* lsu_top.f */
source/lsu_pkg.sv
source/lsu_decode.sv
source/store_buffer.sv
source/load_result.sv
source/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

/* source/load_result.sv */
`timescale 1ns/100ps
`default_nettype none

module load_result (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   req,
    input  wire lsu_pkg::exe_out_t exe,
    input  wire                   exe_valid,
    output lsu_pkg::lsu_resp_t    resp,
    output logic                  ack
);

    import lsu_pkg::*;

    logic [XLEN-1:0] ext_data;
    logic            fill;

    // Extension bit for the narrow loads
    always_comb begin
        fill     = 1'b0;
        ext_data = '0;
        if (exe.kind == OP_LOAD && exe.hit) begin
            case (exe.size)
                SZ_BYTE: begin
                    fill     = exe.is_signed && exe.data[7];
                    ext_data = {{(XLEN-8){fill}}, exe.data[7:0]};
                end
                SZ_HALF: begin
                    fill     = exe.is_signed && exe.data[15];
                    ext_data = {{(XLEN-16){fill}}, exe.data[15:0]};
                end
                default: ext_data = exe.data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp <= '0;
        end else if (exe_valid) begin
            resp.data     <= ext_data;
            resp.phy      <= exe.phy;
            resp.inst_num <= exe.inst_num;
            resp.hit      <= exe.hit;
        end
    end

    // Four-phase ack, drops once the requester lets go of req
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (exe_valid) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/lsu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_decode (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  req,
    input  wire lsu_pkg::lsu_req_t mem_req,
    input  wire                  op_ready,
    output lsu_pkg::mem_op_t     op,
    output logic                 op_valid
);

    import lsu_pkg::*;

    logic      taken;       // Set for the whole req-high phase
    mem_size_e dec_size;
    logic      dec_signed;
    logic      new_req;

    assign new_req = req && !taken;

    // funct3[1:0] gives the width, funct3[2] marks unsigned loads
    always_comb begin
        case (mem_req.funct3[1:0])
            2'b00:   dec_size = SZ_BYTE;
            2'b01:   dec_size = SZ_HALF;
            default: dec_size = SZ_WORD;
        endcase
        dec_signed = (mem_req.kind == OP_LOAD) && !mem_req.funct3[2];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            taken <= 1'b0;
        end else if (!req) begin
            taken <= 1'b0;
        end else if (new_req) begin
            taken <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else if (new_req) begin
            op_valid <= 1'b1;
        end else if (op_valid && op_ready) begin
            op_valid <= 1'b0;  // Handed to execute
        end
    end

    // Payload is only looked at while op_valid is high
    always_ff @(posedge clk) begin
        if (new_req) begin
            op.kind      <= mem_req.kind;
            op.size      <= dec_size;
            op.is_signed <= dec_signed;
            op.phy       <= mem_req.phy;
            op.inst_num  <= mem_req.inst_num;
            op.addr      <= mem_req.addr;
            op.data      <= mem_req.data;
        end
    end

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int XLEN        = 32;
    localparam int INST_W      = 32;
    localparam int PHY_W       = 8;
    localparam int SB_DEPTH    = 32;
    localparam int SB_IDX_W    = 5;
    localparam int NO_DEST_PHY = 160;  // Stores write no register

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE
    } op_kind_e;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } mem_size_e;

    // Request as presented on the LSU port
    typedef struct packed {
        op_kind_e            kind;
        logic [2:0]          funct3;
        logic [PHY_W-1:0]    phy;
        logic [INST_W-1:0]   inst_num;
        logic [XLEN-1:0]     addr;
        logic [XLEN-1:0]     data;
    } lsu_req_t;

    typedef struct packed {
        op_kind_e            kind;
        mem_size_e           size;
        logic                is_signed;
        logic [PHY_W-1:0]    phy;
        logic [INST_W-1:0]   inst_num;
        logic [XLEN-1:0]     addr;
        logic [XLEN-1:0]     data;
    } mem_op_t;

    typedef struct packed {
        op_kind_e            kind;
        mem_size_e           size;
        logic                is_signed;
        logic [PHY_W-1:0]    phy;
        logic [INST_W-1:0]   inst_num;
        logic                hit;
        logic [XLEN-1:0]     data;  // Raw entry data, not yet extended
    } exe_out_t;

    typedef struct packed {
        logic [XLEN-1:0]     data;
        logic [PHY_W-1:0]    phy;
        logic [INST_W-1:0]   inst_num;
        logic                hit;
    } lsu_resp_t;

    typedef struct packed {
        logic                valid;
        logic [XLEN-1:0]     addr;
        logic [INST_W-1:0]   inst_num;
    } rob_commit_t;

endpackage

`default_nettype wire

/* source/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       req,
    input  wire lsu_pkg::lsu_req_t    mem_req,
    input  wire lsu_pkg::rob_commit_t commit,
    input  wire                       flush,
    output logic                      ack,
    output lsu_pkg::lsu_resp_t        resp
);

    import lsu_pkg::*;

    mem_op_t  op;
    logic     op_valid;
    logic     op_ready;
    exe_out_t exe;
    logic     exe_valid;

    lsu_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .mem_req  (mem_req),
        .op_ready (op_ready),
        .op       (op),
        .op_valid (op_valid)
    );

    store_buffer u_store_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .commit    (commit),
        .op        (op),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .exe       (exe),
        .exe_valid (exe_valid)
    );

    load_result u_load_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .exe       (exe),
        .exe_valid (exe_valid),
        .resp      (resp),
        .ack       (ack)
    );

endmodule

`default_nettype wire

/* source/store_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module store_buffer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     flush,
    input  wire lsu_pkg::rob_commit_t commit,
    input  wire lsu_pkg::mem_op_t   op,
    input  wire                     op_valid,
    output logic                    op_ready,
    output lsu_pkg::exe_out_t       exe,
    output logic                    exe_valid
);

    import lsu_pkg::*;

    logic [SB_DEPTH-1:0] sb_valid;
    logic [XLEN-1:0]     sb_addr [SB_DEPTH];
    logic [INST_W-1:0]   sb_inst [SB_DEPTH];
    logic [XLEN-1:0]     sb_data [SB_DEPTH];

    logic                free_found;
    logic [SB_IDX_W-1:0] free_idx;
    logic                match_found;
    logic [SB_IDX_W-1:0] match_idx;
    logic                keep_new;
    logic                fire;
    logic                store_fire;
    logic                load_fire;
    logic [SB_DEPTH-1:0] set_mask;
    logic [SB_DEPTH-1:0] clr_mask;
    logic [SB_DEPTH-1:0] valid_next;

    function automatic logic [XLEN-1:0] trim_data(mem_size_e size, logic [XLEN-1:0] d);
        logic [XLEN-1:0] t;
        case (size)
            SZ_BYTE: t = {{(XLEN-8){1'b0}}, d[7:0]};
            SZ_HALF: t = {{(XLEN-16){1'b0}}, d[15:0]};
            default: t = d;
        endcase
        return t;
    endfunction

    // Lowest free entry wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (!sb_valid[i]) begin
                free_found = 1'b1;
                free_idx   = i[SB_IDX_W-1:0];
            end
        end
    end

    // Pruning keeps at most one valid entry per address
    always_comb begin
        match_found = 1'b0;
        match_idx   = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (sb_valid[i] && sb_addr[i] == op.addr) begin
                match_found = 1'b1;
                match_idx   = i[SB_IDX_W-1:0];
            end
        end
    end

    assign op_ready   = !(op_valid && op.kind == OP_STORE && !free_found);
    assign fire       = op_valid && op_ready;
    assign store_fire = fire && op.kind == OP_STORE;
    assign load_fire  = fire && op.kind == OP_LOAD;

    // Larger instruction number is the younger store
    assign keep_new = !match_found || (sb_inst[match_idx] < op.inst_num);

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (store_fire && keep_new) begin
            set_mask[free_idx] = 1'b1;
            if (match_found) begin
                clr_mask[match_idx] = 1'b1;  // Older duplicate goes
            end
        end
        if (commit.valid) begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                if (sb_valid[i] && sb_addr[i] == commit.addr &&
                    sb_inst[i] == commit.inst_num) begin
                    clr_mask[i] = 1'b1;
                end
            end
        end
        valid_next = (sb_valid & ~clr_mask) | set_mask;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sb_valid <= '0;
        end else if (flush) begin
            sb_valid <= '0;
        end else begin
            sb_valid <= valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_fire && keep_new) begin
            sb_addr[free_idx] <= op.addr;
            sb_inst[free_idx] <= op.inst_num;
            sb_data[free_idx] <= trim_data(op.size, op.data);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            exe.kind      <= op.kind;
            exe.size      <= op.size;
            exe.is_signed <= op.is_signed;
            exe.inst_num  <= op.inst_num;
            if (store_fire) begin
                exe.phy  <= NO_DEST_PHY[PHY_W-1:0];
                exe.hit  <= 1'b0;
                exe.data <= '0;
            end else begin
                exe.phy  <= op.phy;
                exe.hit  <= load_fire && match_found;
                exe.data <= (load_fire && match_found) ? sb_data[match_idx] : '0;
            end
        end
    end

endmodule

`default_nettype wire
